//--- fir_pkg.sv
package fir_pkg;

        typedef logic signed [11:0] sample_t;
        typedef logic signed [8:0]  coeff_t;
        typedef logic signed [12:0] pair_sum_t;
        typedef logic signed [21:0] prod_t;
        typedef logic signed [28:0] acc_t;
        typedef logic [6:0]         tap_idx_t;

        // One engine's work for one sequencer step.
        typedef struct packed {
                pair_sum_t pair_sum;
                tap_idx_t  idx;
                logic      first;
                logic      last;
        } tap_pair_t;

        typedef enum logic [1:0] {
                IDLE,
                RUN,
                DRAIN
        } seq_state_t;

        localparam int N_COEFF    = 101;
        localparam int MAX_DEPTH  = 2 * N_COEFF - 1;
        localparam int HALF_STEPS = 51;

        // Half of a symmetric low-pass response. Entry 100 is the centre tap,
        // and tap k shares its entry with tap 200 - k.
        localparam coeff_t coeff_table [N_COEFF] = '{
                2, 2, 2, 2, 2, 2, 2, 2, 2, 2,
                2, 2, 2, 2, 2, 2, 2, 1, 1, 1,
                0, 0, -1, -1, -2, -3, -4, -5, -6, -7,
                -8, -9, -11, -12, -13, -15, -16, -17, -19, -20,
                -21, -23, -24, -25, -25, -26, -27, -27, -27, -27,
                -26, -26, -25, -23, -22, -20, -17, -14, -11, -8,
                -4, 1, 6, 11, 16, 22, 29, 35, 43, 50,
                58, 66, 74, 82, 91, 100, 109, 118, 127, 135,
                144, 153, 162, 171, 179, 187, 195, 203, 210, 217,
                223, 229, 234, 239, 243, 246, 249, 252, 253, 254,
                255
        };

endpackage

//--- fir_tap_sequencer.sv
`timescale 1ns/1ns

module fir_tap_sequencer import fir_pkg::*; #(
        parameter int DEPTH = 201
) (
        input  logic      clk,
        input  logic      rst,
        input  sample_t   din,
        input  logic      din_valid,
        output tap_pair_t pair_a,
        output tap_pair_t pair_b,
        output logic      step_valid,
        output logic      busy
);

        // A shorter filter keeps the centre of the table and drops outer taps.
        localparam int OFS = (MAX_DEPTH - DEPTH) / 2;

        localparam logic [5:0] LAST_STEP = 6'(HALF_STEPS - 1);
        // The drain covers the product stage, the accumulate stage and the
        // combiner register, so the machine idles as the result appears.
        localparam logic [5:0] END_STEP  = 6'(HALF_STEPS + 2);

        sample_t    delay [DEPTH];
        seq_state_t state;
        logic [5:0] step;
        tap_idx_t   idx_a;
        tap_idx_t   idx_b;
        logic       accept;

        assign accept = (state == IDLE) && din_valid;
        assign busy   = (state != IDLE);

        assign idx_a = tap_idx_t'(step);
        assign idx_b = tap_idx_t'(step) + tap_idx_t'(HALF_STEPS - 1);

        // Positions outside the delay line read as silence.
        function automatic sample_t tap_at(input int pos);
                if (pos < 0 || pos >= DEPTH) begin
                        return '0;
                end
                return delay[pos];
        endfunction

        function automatic pair_sum_t pair_for(input tap_idx_t idx);
                int lo;
                int hi;
                lo = int'(idx) - OFS;
                hi = MAX_DEPTH - 1 - OFS - int'(idx);
                if (lo == hi) begin
                        return tap_at(lo);
                end
                return tap_at(lo) + tap_at(hi);
        endfunction

        // Newest sample sits at position zero.
        always_ff @(posedge clk) begin
                if (rst) begin
                        delay <= '{default: '0};
                end else if (accept) begin
                        delay[0] <= din;
                        for (int i = 1; i < DEPTH; i++) begin
                                delay[i] <= delay[i - 1];
                        end
                end
        end

        always_ff @(posedge clk) begin
                if (rst) begin
                        state      <= IDLE;
                        step       <= '0;
                        step_valid <= 1'b0;
                end else begin
                        step_valid <= 1'b0;
                        case (state)
                                IDLE: begin
                                        step <= '0;
                                        if (accept) begin
                                                state <= RUN;
                                        end
                                end
                                RUN: begin
                                        step_valid <= 1'b1;
                                        step       <= step + 6'd1;
                                        if (step == LAST_STEP) begin
                                                state <= DRAIN;
                                        end
                                end
                                DRAIN: begin
                                        step <= step + 6'd1;
                                        if (step == END_STEP) begin
                                                state <= IDLE;
                                        end
                                end
                                default: begin
                                        state <= IDLE;
                                end
                        endcase
                end
        end

        // Engine A has no pair on the final step and gets a zero sum.
        always_ff @(posedge clk) begin
                if (state == RUN) begin
                        pair_a.pair_sum <= (step == LAST_STEP) ? '0 : pair_for(idx_a);
                        pair_a.idx      <= idx_a;
                        pair_a.first    <= (step == '0);
                        pair_a.last     <= (step == LAST_STEP);
                        pair_b.pair_sum <= pair_for(idx_b);
                        pair_b.idx      <= idx_b;
                        pair_b.first    <= (step == '0);
                        pair_b.last     <= (step == LAST_STEP);
                end
        end

endmodule

//--- fir_half_mac.sv
`timescale 1ns/1ns

module fir_half_mac import fir_pkg::*; (
        input  logic      clk,
        input  logic      rst,
        input  tap_pair_t pair,
        input  logic      step_valid,
        output acc_t      partial,
        output logic      done
);

        prod_t prod;
        logic  prod_valid;
        logic  prod_first;
        logic  prod_last;
        acc_t  acc;

        // Stage one looks up the coefficient and forms the product.
        always_ff @(posedge clk) begin
                if (step_valid) begin
                        prod       <= pair.pair_sum * coeff_table[pair.idx];
                        prod_first <= pair.first;
                        prod_last  <= pair.last;
                end
        end

        always_ff @(posedge clk) begin
                if (rst) begin
                        prod_valid <= 1'b0;
                end else begin
                        prod_valid <= step_valid;
                end
        end

        // Stage two accumulates. The first product of a run restarts the sum.
        always_ff @(posedge clk) begin
                if (prod_valid) begin
                        if (prod_first) begin
                                acc <= acc_t'(prod);
                        end else begin
                                acc <= acc + acc_t'(prod);
                        end
                end
        end

        always_ff @(posedge clk) begin
                if (rst) begin
                        done <= 1'b0;
                end else begin
                        done <= prod_valid && prod_last;
                end
        end

        assign partial = acc;

endmodule

//--- fir_combine.sv
`timescale 1ns/1ns

module fir_combine import fir_pkg::*; #(
        parameter int OUT_SHIFT = 8
) (
        input  logic    clk,
        input  logic    rst,
        input  acc_t    partial_a,
        input  acc_t    partial_b,
        input  logic    done,
        output sample_t dout,
        output logic    dout_valid
);

        // Half of one output step, for round-half-up.
        localparam acc_t HALF_STEP = acc_t'(1) <<< (OUT_SHIFT - 1);
        localparam acc_t SAT_MAX   = acc_t'(2047);
        localparam acc_t SAT_MIN   = acc_t'(-2048);

        acc_t    total;
        acc_t    rounded;
        acc_t    shifted;
        sample_t clamped;

        always_comb begin
                total   = partial_a + partial_b;
                rounded = total + HALF_STEP;
                shifted = rounded >>> OUT_SHIFT;
                if (shifted > SAT_MAX) begin
                        clamped = sample_t'(SAT_MAX);
                end else if (shifted < SAT_MIN) begin
                        clamped = sample_t'(SAT_MIN);
                end else begin
                        clamped = sample_t'(shifted);
                end
        end

        always_ff @(posedge clk) begin
                if (rst) begin
                        dout       <= '0;
                        dout_valid <= 1'b0;
                end else begin
                        dout_valid <= done;
                        if (done) begin
                                dout <= clamped;
                        end
                end
        end

endmodule

//--- fir_decimator.sv
`timescale 1ns/1ns

module fir_decimator import fir_pkg::*; #(
        parameter int OUT_SHIFT = 8,
        parameter int DEPTH     = 201
) (
        input  logic    clk,
        input  logic    rst,
        input  sample_t din,
        input  logic    din_valid,
        output sample_t dout,
        output logic    dout_valid,
        output logic    busy
);

        tap_pair_t pair_a;
        tap_pair_t pair_b;
        logic      step_valid;
        acc_t      partial_a;
        acc_t      partial_b;
        logic      done_a;

        fir_tap_sequencer #(
                .DEPTH (DEPTH)
        ) sequencer (
                .clk        (clk),
                .rst        (rst),
                .din        (din),
                .din_valid  (din_valid),
                .pair_a     (pair_a),
                .pair_b     (pair_b),
                .step_valid (step_valid),
                .busy       (busy)
        );

        fir_half_mac engine_a (
                .clk        (clk),
                .rst        (rst),
                .pair       (pair_a),
                .step_valid (step_valid),
                .partial    (partial_a),
                .done       (done_a)
        );

        // Both engines finish on the same edge, so only engine A reports done.
        fir_half_mac engine_b (
                .clk        (clk),
                .rst        (rst),
                .pair       (pair_b),
                .step_valid (step_valid),
                .partial    (partial_b),
                .done       ()
        );

        fir_combine #(
                .OUT_SHIFT (OUT_SHIFT)
        ) combine (
                .clk        (clk),
                .rst        (rst),
                .partial_a  (partial_a),
                .partial_b  (partial_b),
                .done       (done_a),
                .dout       (dout),
                .dout_valid (dout_valid)
        );

endmodule

//--- fir_decimator_tb.sv
`timescale 1ns/1ns

module fir_decimator_tb import fir_pkg::*; ();

        localparam int OUT_SHIFT  = 8;
        localparam int DEPTH      = 201;
        localparam int LATENCY    = 54;
        localparam int WAIT_LIMIT = 80;

        localparam int RESET_SAMPLES   = 1;
        localparam int IMPULSE_SAMPLES = 201;
        localparam int LATENCY_SAMPLES = 1;
        localparam int STROBE_SAMPLES  = 4;
        localparam int SAT_RUN         = 120;
        localparam int RANDOM_SAMPLES  = 40;
        localparam int TOTAL_SAMPLES   = RESET_SAMPLES + IMPULSE_SAMPLES + LATENCY_SAMPLES
                                         + STROBE_SAMPLES + 2 * SAT_RUN + RANDOM_SAMPLES;
        // Each sample gets 60 clock periods of 100 ns, plus some slack.
        localparam longint WATCHDOG_NS = longint'(TOTAL_SAMPLES) * 60 * 100 + 10_000;

        logic    clk = 1'b0;
        logic    rst;
        sample_t din;
        logic    din_valid;
        sample_t dout;
        logic    dout_valid;
        logic    busy;

        sample_t history [DEPTH];
        integer  seed;
        int      errors;
        int      test_errors;
        int      pass_count;
        int      fail_count;
        string   test_name;

        fir_decimator #(
                .OUT_SHIFT (OUT_SHIFT),
                .DEPTH     (DEPTH)
        ) dut (
                .clk        (clk),
                .rst        (rst),
                .din        (din),
                .din_valid  (din_valid),
                .dout       (dout),
                .dout_valid (dout_valid),
                .busy       (busy)
        );

        always #50 clk = ~clk;

        initial begin
                #(WATCHDOG_NS);
                $display("Watchdog expired after %0d ns with tests still running.", WATCHDOG_NS);
                $display("STATUS: FAIL");
                $finish;
        end

        // Newest sample at index zero, as the filter sees it.
        task automatic push_history(input sample_t x);
                for (int k = DEPTH - 1; k > 0; k--) begin
                        history[k] = history[k - 1];
                end
                history[0] = x;
        endtask

        // Full 201-tap convolution, then round half up, shift and clamp.
        function automatic sample_t model_output();
                longint sum;
                longint scaled;
                int     c;
                sum = 0;
                for (int k = 0; k < DEPTH; k++) begin
                        c = (k <= DEPTH / 2) ? k : DEPTH - 1 - k;
                        sum += longint'(coeff_table[c]) * longint'(history[k]);
                end
                scaled = (sum + (longint'(1) <<< (OUT_SHIFT - 1))) >>> OUT_SHIFT;
                if (scaled > 2047) begin
                        return sample_t'(2047);
                end
                if (scaled < -2048) begin
                        return sample_t'(-2048);
                end
                return sample_t'(scaled);
        endfunction

        task automatic report_failure(input string msg);
                $display("Error in %s: %s", test_name, msg);
                errors++;
        endtask

        task automatic check_sample(input string label, input sample_t expected,
                                    input sample_t actual);
                if (actual !== expected) begin
                        $display("Mismatch in %s (%s): expected %0d, got %0d",
                                 test_name, label, expected, actual);
                        errors++;
                end
        endtask

        task automatic check_level(input string label, input logic expected, input logic actual);
                if (actual !== expected) begin
                        $display("Mismatch in %s (%s): expected %b, got %b",
                                 test_name, label, expected, actual);
                        errors++;
                end
        endtask

        task automatic start_test(input string name);
                test_name   = name;
                test_errors = errors;
        endtask

        task automatic finish_test();
                if (errors == test_errors) begin
                        pass_count++;
                        $display("Test %s passed", test_name);
                end else begin
                        fail_count++;
                        $display("Test %s failed with %0d errors", test_name, errors - test_errors);
                end
        endtask

        // Called right after a falling edge, where busy is stable.
        task automatic wait_idle();
                int n;
                n = 0;
                while (busy !== 1'b0 && n < WAIT_LIMIT) begin
                        @(negedge clk);
                        n++;
                end
                if (busy !== 1'b0) begin
                        report_failure("busy never fell, the filter stayed occupied");
                end
        endtask

        // Returns on the edge that accepts the sample.
        task automatic send_sample(input sample_t x);
                wait_idle();
                @(posedge clk);
                din       <= x;
                din_valid <= 1'b1;
                @(posedge clk);
                din_valid <= 1'b0;
                push_history(x);
        endtask

        task automatic collect_output(input string label);
                int      n;
                sample_t expected;
                expected = model_output();
                n = 0;
                @(negedge clk);
                while (dout_valid !== 1'b1 && n < WAIT_LIMIT) begin
                        @(negedge clk);
                        n++;
                end
                if (dout_valid !== 1'b1) begin
                        report_failure("dout_valid never arrived for an accepted sample");
                end else begin
                        check_sample(label, expected, dout);
                        @(negedge clk);
                        if (dout_valid !== 1'b0) begin
                                report_failure("dout_valid was high for a second cycle");
                        end
                end
        endtask

        task automatic verify_reset_state();
                start_test("reset_state");
                @(negedge clk);
                check_level("busy after reset", 1'b0, busy);
                check_level("dout_valid after reset", 1'b0, dout_valid);
                check_sample("dout after reset", sample_t'(0), dout);
                send_sample(sample_t'(0));
                collect_output("zero input");
                finish_test();
        endtask

        task automatic trace_impulse();
                start_test("impulse");
                send_sample(sample_t'(256));
                collect_output("impulse sample");
                for (int i = 1; i < IMPULSE_SAMPLES; i++) begin
                        send_sample(sample_t'(0));
                        collect_output("impulse tail");
                end
                finish_test();
        endtask

        task automatic measure_latency();
                sample_t expected;
                logic    early;
                logic    busy_first;
                logic    busy_before;
                start_test("latency");
                early       = 1'b0;
                busy_first  = 1'b0;
                busy_before = 1'b0;
                send_sample(sample_t'(-777));
                expected = model_output();
                // Sample n of this loop shows the state after the n-th edge past acceptance.
                for (int n = 0; n <= LATENCY; n++) begin
                        @(negedge clk);
                        if (n < LATENCY && dout_valid === 1'b1) begin
                                early = 1'b1;
                        end
                        if (n == 0) begin
                                busy_first = busy;
                        end
                        if (n == LATENCY - 1) begin
                                busy_before = busy;
                        end
                end
                check_level("busy after accept", 1'b1, busy_first);
                check_level("dout_valid before edge 54", 1'b0, early);
                check_level("busy one edge before output", 1'b1, busy_before);
                check_level("dout_valid on edge 54", 1'b1, dout_valid);
                check_level("busy on edge 54", 1'b0, busy);
                check_sample("latency output", expected, dout);
                @(negedge clk);
                check_level("dout_valid one edge later", 1'b0, dout_valid);
                finish_test();
        endtask

        task automatic ignore_busy_strobe();
                start_test("ignored_strobe");
                send_sample(sample_t'(500));
                repeat (10) @(posedge clk);
                @(negedge clk);
                check_level("busy during run", 1'b1, busy);
                @(posedge clk);
                din       <= sample_t'(-1500);
                din_valid <= 1'b1;
                @(posedge clk);
                din_valid <= 1'b0;
                collect_output("sample before strobe");
                send_sample(sample_t'(300));
                collect_output("first after strobe");
                send_sample(sample_t'(-700));
                collect_output("second after strobe");
                finish_test();
        endtask

        task automatic drive_saturation();
                start_test("saturation");
                for (int i = 0; i < SAT_RUN; i++) begin
                        send_sample(sample_t'(2047));
                        collect_output("positive run");
                end
                check_sample("positive clamp", sample_t'(2047), dout);
                for (int i = 0; i < SAT_RUN; i++) begin
                        send_sample(sample_t'(-2048));
                        collect_output("negative run");
                end
                check_sample("negative clamp", sample_t'(-2048), dout);
                finish_test();
        endtask

        task automatic stream_random();
                sample_t x;
                start_test("random_stream");
                for (int i = 0; i < RANDOM_SAMPLES; i++) begin
                        x = sample_t'($random(seed));
                        send_sample(x);
                        collect_output("random sample");
                end
                finish_test();
        endtask

        initial begin
                seed       = 32'h8c68;
                errors     = 0;
                pass_count = 0;
                fail_count = 0;
                rst        = 1'b1;
                din        = '0;
                din_valid  = 1'b0;
                for (int k = 0; k < DEPTH; k++) begin
                        history[k] = '0;
                end
                repeat (2) @(posedge clk);
                rst <= 1'b0;

                verify_reset_state();
                trace_impulse();
                measure_latency();
                ignore_busy_strobe();
                drive_saturation();
                stream_random();

                $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
                if (fail_count == 0 && errors == 0) begin
                        $display("STATUS: PASS");
                end else begin
                        $display("STATUS: FAIL");
                end
                $finish;
        end

endmodule

//--- fir_decimator.f
fir_pkg.sv
fir_tap_sequencer.sv
fir_half_mac.sv
fir_combine.sv
fir_decimator.sv
fir_decimator_tb.sv

//--- Bender.yml
package:
  name: fir_decimator

sources:
  - fir_pkg.sv
  - fir_tap_sequencer.sv
  - fir_half_mac.sv
  - fir_combine.sv
  - fir_decimator.sv
  - target: test
    files:
      - fir_decimator_tb.sv
